//--- bench/lcd_subsystem_asserts.sv
`timescale 1ns/1ps

module lcd_subsystem_asserts (
	input logic       clk,
	input logic       rst,
	input logic       lcd_e,
	input logic       lcd_rs,
	input logic       lcd_rw,
	input logic [7:0] lcd_data,
	input logic       busy,
	input logic       full
);

	int err_count;

	initial err_count = 0;

	// fields valid the cycle before e rises, held through the falling cycle
	bus_stable: assert property (@(posedge clk) disable iff (rst)
		(lcd_e || $fell(lcd_e)) |-> $stable({lcd_rs, lcd_rw, lcd_data}))
		else begin
			$error("rs, rw or data changed around an enable pulse");
			err_count = err_count + 1;
		end

	reset_state: assert property (@(posedge clk)
		rst |=> (!lcd_e && busy && !full && !lcd_rs && !lcd_rw && lcd_data == 8'h00))
		else begin
			$error("outputs not at their reset values after rst");
			err_count = err_count + 1;
		end

	busy_with_e: assert property (@(posedge clk) disable iff (rst) lcd_e |-> busy)
		else begin
			$error("e high while busy is low");
			err_count = err_count + 1;
		end

	// idle panel bus is fully cleared
	idle_bus: assert property (@(posedge clk) disable iff (rst)
		!busy |-> (!lcd_e && !lcd_rs && !lcd_rw && lcd_data == 8'h00))
		else begin
			$error("panel bus not cleared while idle");
			err_count = err_count + 1;
		end

endmodule

bind lcd_subsystem lcd_subsystem_asserts u_asserts (
	.clk      (clk),
	.rst      (rst),
	.lcd_e    (lcd_e),
	.lcd_rs   (lcd_rs),
	.lcd_rw   (lcd_rw),
	.lcd_data (lcd_data),
	.busy     (busy),
	.full     (full)
);

//--- bench/lcd_subsystem_tb.sv
`timescale 1ns/1ps

module lcd_subsystem_tb
	import lcd_pkg::*;
();

	logic             clk = 1'b0;
	logic             rst;
	logic [CFG_W-1:0] cfg;
	logic             wr_en;
	logic [CMD_W-1:0] wr_cmd;
	logic             lcd_e;
	logic             lcd_rs;
	logic             lcd_rw;
	logic [7:0]       lcd_data;
	logic             busy;
	logic             full;

	integer           seed;
	int               cyc;        // cycles since reset release
	logic             e_prev;
	int               high_cnt;
	logic [CMD_W-1:0] bus_q[$];   // {rs, rw, data} at each rise of e
	int               rise_q[$];
	int               width_q[$];
	logic [CMD_W-1:0] exp_q[$];   // expected bus value per pulse

	lcd_subsystem uut (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg),
		.wr_en    (wr_en),
		.wr_cmd   (wr_cmd),
		.lcd_e    (lcd_e),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_data (lcd_data),
		.busy     (busy),
		.full     (full)
	);

	always #2 clk = ~clk;  // 4 ns period

	// panel side, sampled away from the driving edge
	always @(negedge clk) begin
		if (rst) begin
			cyc      = 0;
			e_prev   = 1'b0;
			high_cnt = 0;
		end else begin
			cyc = cyc + 1;
			if (lcd_e && !e_prev) begin
				bus_q.push_back({lcd_rs, lcd_rw, lcd_data});
				rise_q.push_back(cyc);
			end
			if (lcd_e) begin
				high_cnt = high_cnt + 1;
			end else if (e_prev) begin
				width_q.push_back(high_cnt);  // pulse just ended
				high_cnt = 0;
			end
			e_prev = lcd_e;
		end
	end

	task automatic report_failure();
		$display("CHECKS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// bound protocol assertions count their failures
	always @(posedge clk) begin
		if (uut.u_asserts.err_count != 0) begin
			$display("a bus protocol assertion failed");
			report_failure();
		end
	end

	task automatic check_val(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_at_least(input string name, input int expected, input int actual);
		assert (actual >= expected) else begin
			$display("[FAIL] %s expected at least %0d actual %0d", name, expected, actual);
			report_failure();
		end
	endtask

	function automatic logic [CMD_W-1:0] rand_cmd();
		int r;
		r = $random(seed);
		return r[CMD_W-1:0];
	endfunction

	task automatic push_cmd(input logic [CMD_W-1:0] c);
		@(posedge clk);
		wr_en  <= 1'b1;
		wr_cmd <= c;
	endtask

	task automatic release_wr();
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic wait_pulses(input int n, input int limit);
		int t;
		t = 0;
		while (width_q.size() < n) begin
			@(posedge clk);
			t++;
			if (t > limit) begin
				$display("timeout with %0d of %0d enable pulses seen", width_q.size(), n);
				report_failure();
			end
		end
	endtask

	task automatic wait_idle(input int limit);
		int t;
		t = 0;
		while (busy) begin
			@(negedge clk);
			t++;
			if (t > limit) begin
				$display("timeout waiting for busy to go low");
				report_failure();
			end
		end
	endtask

	task automatic check_pulses(input string name, input int first, input int n, input int width);
		for (int k = first; k < first + n; k++) begin
			check_val({name, " bus value"}, exp_q[k], bus_q[k]);
			check_val({name, " e width"}, width, width_q[k]);
		end
	endtask

	task automatic check_spacing(input string name, input int first, input int n);
		for (int k = first + 1; k < first + n; k++) begin
			check_val({name, " e spacing"}, T_CMD_TOTAL_US * CLK_PER_US, rise_q[k] - rise_q[k-1]);
		end
	endtask

	initial begin
		logic [CMD_W-1:0] cmd_val;
		seed   = 32'habc0;
		rst    = 1'b1;
		wr_en  = 1'b0;
		wr_cmd = '0;
		cfg    = CFG_W'($random(seed));

		// HD44780 N and F in function set, D C B in display, I/D S in entry
		exp_q.push_back({2'b00, OP_FUNC_SET | (8'(cfg[6]) << 3) | (8'(cfg[5]) << 2)});
		exp_q.push_back({2'b00, OP_DISP_CTRL | 8'(cfg[4:2])});
		exp_q.push_back({2'b00, OP_CLEAR});
		exp_q.push_back({2'b00, OP_ENTRY_MODE | 8'(cfg[1:0])});

		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// fill the queue while the panel still powers up
		repeat (4) begin
			cmd_val = rand_cmd();
			exp_q.push_back(cmd_val);
			push_cmd(cmd_val);
		end
		push_cmd(rand_cmd());  // sampled with the queue full
		@(negedge clk);
		check_val("backpressure full", 1, full);
		release_wr();
		@(negedge clk);
		check_val("backpressure full after drop", 1, full);

		wait_pulses(8, 4000);
		wait_idle(500);
		check_at_least("powerup delay", T_POWERUP_US * CLK_PER_US, rise_q[0]);
		check_pulses("init", 0, 4, T_INIT_E_US * CLK_PER_US);
		check_pulses("backpressure", 4, 4, T_E_HIGH_US * CLK_PER_US);
		check_spacing("backpressure", 4, 4);
		check_val("backpressure pulse count", 8, bus_q.size());

		cmd_val = rand_cmd();
		exp_q.push_back(cmd_val);
		push_cmd(cmd_val);
		release_wr();
		wait_pulses(9, 500);
		wait_idle(500);
		check_pulses("single write", 8, 1, T_E_HIGH_US * CLK_PER_US);

		repeat (4) begin
			cmd_val = rand_cmd();
			exp_q.push_back(cmd_val);
			push_cmd(cmd_val);
		end
		release_wr();
		wait_pulses(13, 1000);
		wait_idle(500);
		check_pulses("ordering", 9, 4, T_E_HIGH_US * CLK_PER_US);
		check_spacing("ordering", 9, 4);
		check_val("total pulse count", 13, bus_q.size());

		if (uut.u_asserts.err_count != 0) begin
			$display("bus protocol assertions fired %0d times", uut.u_asserts.err_count);
			report_failure();
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- design/lcd_bus_driver.sv
`timescale 1ns/1ps

module lcd_bus_driver
	import lcd_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [CFG_W-1:0] cfg,
	input  logic             init_load,
	input  logic [1:0]       init_step,
	input  logic             cmd_load,
	input  logic [CMD_W-1:0] cmd,
	input  logic             e_level,
	input  logic             clear,
	output logic             lcd_e,
	output logic             lcd_rs,
	output logic             lcd_rw,
	output logic [7:0]       lcd_data
);

	logic [7:0] init_byte;

	// opcode with the cfg fields of this step merged in
	always_comb begin
		case (init_step)
			INIT_FUNC:  init_byte = OP_FUNC_SET | {4'b0000, cfg[6:5], 2'b00};
			INIT_DISP:  init_byte = OP_DISP_CTRL | {5'b00000, cfg[4:2]};
			INIT_CLEAR: init_byte = OP_CLEAR;
			INIT_ENTRY: init_byte = OP_ENTRY_MODE | {6'b000000, cfg[1:0]};
			default:    init_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lcd_e    <= 1'b0;
			lcd_rs   <= 1'b0;
			lcd_rw   <= 1'b0;
			lcd_data <= 8'h00;
		end else begin
			lcd_e <= e_level;  // one cycle behind the sequencer state
			if (cmd_load) begin
				lcd_rs   <= cmd[CMD_RS];
				lcd_rw   <= cmd[CMD_RW];  // passed through, never read back
				lcd_data <= cmd[7:0];
			end else if (init_load) begin
				lcd_rs   <= 1'b0;  // instruction register
				lcd_rw   <= 1'b0;
				lcd_data <= init_byte;
			end else if (clear) begin
				lcd_rs   <= 1'b0;
				lcd_rw   <= 1'b0;
				lcd_data <= 8'h00;
			end
		end
	end

endmodule

//--- design/lcd_cmd_queue.sv
`timescale 1ns/1ps

module lcd_cmd_queue
	import lcd_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic [CMD_W-1:0] push_data,
	input  logic             pop,
	output logic [CMD_W-1:0] head,
	output logic             empty,
	output logic             full
);

	logic [CMD_W-1:0]       mem [QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_CNT_W-1:0] count;
	logic                   do_push;
	logic                   do_pop;

	assign empty   = (count == '0);
	assign full    = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
	assign do_push = push && !full;  // dropped when full, even with a pop
	assign do_pop  = pop && !empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // none or both
			endcase
		end
	end

endmodule

//--- design/lcd_pkg.sv
package lcd_pkg;

	// panel timing in microseconds
	localparam int CLK_PER_US      = 2;   // kept low for short sims
	localparam int T_POWERUP_US    = 500;
	localparam int T_INIT_E_US     = 10;
	localparam int T_WAIT_FUNC_US  = 50;
	localparam int T_WAIT_DISP_US  = 50;
	localparam int T_WAIT_CLEAR_US = 200;
	localparam int T_WAIT_ENTRY_US = 100;
	localparam int T_SETUP_US      = 1;
	localparam int T_E_HIGH_US     = 13;
	localparam int T_E_LOW_US      = 13;
	localparam int T_CMD_TOTAL_US  = 50;

	// same delays in clock cycles
	localparam int POWERUP_CYC    = T_POWERUP_US * CLK_PER_US;
	localparam int INIT_E_CYC     = T_INIT_E_US * CLK_PER_US;
	localparam int WAIT_FUNC_CYC  = T_WAIT_FUNC_US * CLK_PER_US;
	localparam int WAIT_DISP_CYC  = T_WAIT_DISP_US * CLK_PER_US;
	localparam int WAIT_CLEAR_CYC = T_WAIT_CLEAR_US * CLK_PER_US;
	localparam int WAIT_ENTRY_CYC = T_WAIT_ENTRY_US * CLK_PER_US;
	localparam int SETUP_CYC      = T_SETUP_US * CLK_PER_US;
	localparam int E_HIGH_CYC     = T_E_HIGH_US * CLK_PER_US;
	localparam int E_LOW_CYC      = T_E_LOW_US * CLK_PER_US;
	localparam int HOLD_CYC       = (T_CMD_TOTAL_US - T_SETUP_US - T_E_HIGH_US - T_E_LOW_US)
		* CLK_PER_US;

	localparam int TIMER_W = 15;  // holds POWERUP_CYC with margin

	// write request queue
	localparam int QUEUE_DEPTH = 4;  // power of two, pointers wrap
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

	// request {rs, rw, data[7:0]}
	localparam int CMD_W  = 10;
	localparam int CMD_RS = 9;
	localparam int CMD_RW = 8;

	// cfg {lines, font, display on, cursor, blink, increment, shift}
	localparam int CFG_W = 7;

	// init steps, sent in ascending order
	localparam logic [1:0] INIT_FUNC  = 2'd0;
	localparam logic [1:0] INIT_DISP  = 2'd1;
	localparam logic [1:0] INIT_CLEAR = 2'd2;
	localparam logic [1:0] INIT_ENTRY = 2'd3;

	// fixed opcode bits, cfg fields are zero here
	localparam logic [7:0] OP_FUNC_SET   = 8'b0011_0000;  // 8-bit bus
	localparam logic [7:0] OP_DISP_CTRL  = 8'b0000_1000;
	localparam logic [7:0] OP_CLEAR      = 8'b0000_0001;
	localparam logic [7:0] OP_ENTRY_MODE = 8'b0000_0100;

endpackage

//--- design/lcd_sequencer.sv
`timescale 1ns/1ps

module lcd_sequencer
	import lcd_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               q_empty,
	output logic               q_pop,
	input  logic               tmr_done,
	output logic               tmr_load,
	output logic [TIMER_W-1:0] tmr_cycles,
	output logic               init_load,
	output logic [1:0]         init_step,
	output logic               cmd_load,
	output logic               drv_e,
	output logic               drv_clear,
	output logic               busy
);

	typedef enum logic [2:0] {
		S_POWERUP,
		S_INIT_PULSE,
		S_INIT_WAIT,
		S_IDLE,
		S_SETUP,
		S_E_HIGH,
		S_E_LOW,
		S_HOLD
	} state_t;

	state_t     state;
	state_t     state_nxt;
	logic [1:0] step;
	logic [1:0] step_nxt;
	logic       pwr_arm;    // first cycle out of reset
	logic [1:0] clr_pipe;   // clears init data a cycle after e falls
	logic       start_slot;

	always_comb begin
		state_nxt  = state;
		step_nxt   = step;
		tmr_load   = 1'b0;
		tmr_cycles = '0;
		init_load  = 1'b0;
		cmd_load   = 1'b0;
		q_pop      = 1'b0;
		drv_clear  = clr_pipe[1];
		start_slot = 1'b0;

		case (state)
			S_POWERUP: begin
				if (pwr_arm) begin
					tmr_load   = 1'b1;
					tmr_cycles = TIMER_W'(POWERUP_CYC - 1);  // arm cycle counts too
				end else if (tmr_done) begin
					state_nxt  = S_INIT_PULSE;
					init_load  = 1'b1;
					tmr_load   = 1'b1;
					tmr_cycles = TIMER_W'(INIT_E_CYC);
				end
			end
			S_INIT_PULSE: begin
				if (tmr_done) begin
					state_nxt = S_INIT_WAIT;
					tmr_load  = 1'b1;
					case (step)
						INIT_FUNC:  tmr_cycles = TIMER_W'(WAIT_FUNC_CYC);
						INIT_DISP:  tmr_cycles = TIMER_W'(WAIT_DISP_CYC);
						INIT_CLEAR: tmr_cycles = TIMER_W'(WAIT_CLEAR_CYC);
						default:    tmr_cycles = TIMER_W'(WAIT_ENTRY_CYC);
					endcase
				end
			end
			S_INIT_WAIT: begin
				if (tmr_done) begin
					if (step == INIT_ENTRY) begin
						state_nxt = S_IDLE;
					end else begin
						step_nxt   = step + 2'd1;
						state_nxt  = S_INIT_PULSE;
						init_load  = 1'b1;
						tmr_load   = 1'b1;
						tmr_cycles = TIMER_W'(INIT_E_CYC);
					end
				end
			end
			S_IDLE: begin
				start_slot = !q_empty;
			end
			S_SETUP: begin
				if (tmr_done) begin
					state_nxt  = S_E_HIGH;
					tmr_load   = 1'b1;
					tmr_cycles = TIMER_W'(E_HIGH_CYC);
				end
			end
			S_E_HIGH: begin
				if (tmr_done) begin
					state_nxt  = S_E_LOW;
					tmr_load   = 1'b1;
					tmr_cycles = TIMER_W'(E_LOW_CYC);
				end
			end
			S_E_LOW: begin
				if (tmr_done) begin
					state_nxt  = S_HOLD;
					tmr_load   = 1'b1;
					tmr_cycles = TIMER_W'(HOLD_CYC + 1);  // gets the cycle setup gave up
				end
			end
			S_HOLD: begin
				if (tmr_done) begin
					if (!q_empty) begin
						start_slot = 1'b1;  // back to back, no idle cycle
					end else begin
						state_nxt = S_IDLE;
						drv_clear = 1'b1;
					end
				end
			end
			default: state_nxt = S_IDLE;
		endcase

		// the bus lags the state by a cycle, so the load edge opens setup
		if (start_slot) begin
			state_nxt  = S_SETUP;
			q_pop      = 1'b1;
			cmd_load   = 1'b1;
			tmr_load   = 1'b1;
			tmr_cycles = TIMER_W'(SETUP_CYC - 1);
		end
	end

	assign init_step = step_nxt;  // step whose byte init_load latches
	assign drv_e     = (state == S_INIT_PULSE) || (state == S_E_HIGH);
	assign busy      = !((state == S_IDLE) && q_empty);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= S_POWERUP;
			step     <= INIT_FUNC;
			pwr_arm  <= 1'b1;
			clr_pipe <= 2'b00;
		end else begin
			state    <= state_nxt;
			step     <= step_nxt;
			pwr_arm  <= 1'b0;
			clr_pipe <= {clr_pipe[0], (state == S_INIT_PULSE) && tmr_done};
		end
	end

endmodule

//--- design/lcd_subsystem.sv
`timescale 1ns/1ps

module lcd_subsystem
	import lcd_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [CFG_W-1:0] cfg,
	input  logic             wr_en,
	input  logic [CMD_W-1:0] wr_cmd,
	output logic             lcd_e,
	output logic             lcd_rs,
	output logic             lcd_rw,
	output logic [7:0]       lcd_data,
	output logic             busy,
	output logic             full
);

	logic               tmr_load;
	logic [TIMER_W-1:0] tmr_cycles;
	logic               tmr_done;
	logic               q_pop;
	logic               q_empty;
	logic [CMD_W-1:0]   q_head;
	logic               drv_init_load;
	logic [1:0]         init_step;
	logic               drv_cmd_load;
	logic               drv_e;
	logic               drv_clear;

	lcd_sequencer u_sequencer (
		.clk        (clk),
		.rst        (rst),
		.q_empty    (q_empty),
		.q_pop      (q_pop),
		.tmr_done   (tmr_done),
		.tmr_load   (tmr_load),
		.tmr_cycles (tmr_cycles),
		.init_load  (drv_init_load),
		.init_step  (init_step),
		.cmd_load   (drv_cmd_load),
		.drv_e      (drv_e),
		.drv_clear  (drv_clear),
		.busy       (busy)
	);

	lcd_timer u_timer (
		.clk    (clk),
		.rst    (rst),
		.load   (tmr_load),
		.cycles (tmr_cycles),
		.done   (tmr_done)
	);

	lcd_cmd_queue u_queue (
		.clk       (clk),
		.rst       (rst),
		.push      (wr_en),
		.push_data (wr_cmd),
		.pop       (q_pop),
		.head      (q_head),
		.empty     (q_empty),
		.full      (full)
	);

	lcd_bus_driver u_bus_driver (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.init_load (drv_init_load),
		.init_step (init_step),
		.cmd_load  (drv_cmd_load),
		.cmd       (q_head),
		.e_level   (drv_e),
		.clear     (drv_clear),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_data  (lcd_data)
	);

endmodule

//--- design/lcd_timer.sv
`timescale 1ns/1ps

module lcd_timer
	import lcd_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               load,
	input  logic [TIMER_W-1:0] cycles,
	output logic               done
);

	logic [TIMER_W-1:0] cnt;
	logic               active;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt    <= '0;
			active <= 1'b0;
		end else if (load) begin
			cnt    <= cycles - 1'b1;  // done shows in the last loaded cycle
			active <= 1'b1;
		end else if (active) begin
			if (cnt == '0) begin
				active <= 1'b0;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// high for one cycle, a reload on that cycle keeps it running
	assign done = active && (cnt == '0);

endmodule

//--- lcd_subsystem.f
design/lcd_pkg.sv
design/lcd_timer.sv
design/lcd_cmd_queue.sv
design/lcd_bus_driver.sv
design/lcd_sequencer.sv
design/lcd_subsystem.sv
bench/lcd_subsystem_asserts.sv
bench/lcd_subsystem_tb.sv
